/* src.f */
+incdir+rtl
rtl/apb_pkg.sv
rtl/queue_pkg.sv
rtl/apb_cmd_port.sv
rtl/fifo_flopped.sv
rtl/cmd_drain.sv
rtl/cmd_queue_top.sv
bench/cmd_queue_checker.sv
bench/cmd_queue_tb.sv

/* Makefile */
# Verilator build and run of the command queue testbench

LOG = sim.log

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -f src.f --top-module cmd_queue_tb -o cmd_queue_sim

run: build
	-./obj_dir/cmd_queue_sim +verilator+error+limit+100 > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Some tests failed" $(LOG); then echo "Simulation FAILED"; exit 1; fi
	@grep -q "All tests passed" $(LOG) || (echo "Simulation ended without a result"; exit 1)

lint:
	verilator --lint-only -Wall --timing --assert -f src.f --top-module cmd_queue_tb

clean:
	rm -rf obj_dir $(LOG)

/* bench/cmd_queue_tb.sv */
`timescale 1ns/1ps
`include "queue_settings.svh"

module cmd_queue_tb;
    import apb_pkg::*;
    import queue_pkg::*;

    localparam int N_BASIC  = 40;
    localparam int N_RANDOM = 300;
    // All reads and writes, the fill tests counted with their drains
    localparam int NUM_OPS  = 1 + N_BASIC + 2 * (`QUEUE_DEPTH + 4) + 2 + N_RANDOM;

    logic        clk;
    logic        rst;
    apb_req_t    apb_req;
    apb_rsp_t    apb_rsp;
    logic        out_valid;
    q_item_t     out_item;
    logic        out_ready;
    logic        random_ready;
    logic [15:0] lfsr_state;

    // Reference model state
    q_word_t stored_q[$];
    q_item_t exp_q[$];
    int      exp_level;
    logic    exp_valid;
    logic    exp_ovf;
    q_seq_t  exp_seq;
    int      n_seen;

    cmd_queue_top u_cmd_queue_top
    (
        .clk       (clk),
        .rst       (rst),
        .apb_req   (apb_req),
        .apb_rsp   (apb_rsp),
        .out_valid (out_valid),
        .out_item  (out_item),
        .out_ready (out_ready)
    );

    initial
    begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // ******************************
    // Helpers
    // ******************************

    task automatic abort_run();
        $display("Some tests failed");
        $fatal(1, "Run stopped at the first error");
    endtask

    task automatic check_equal(input logic [63:0] got, input logic [63:0] want, input string what);
        if (got !== want)
        begin
            $display("Error at %0t ns: %s is %0h, expected %0h", $time, what, got, want);
            abort_run();
        end
    endtask

    // Galois form, taps for x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic take_bit();
        logic bit_out;
        bit_out    = lfsr_state[0];
        lfsr_state = lfsr_state >> 1;
        if (bit_out)
            lfsr_state = lfsr_state ^ 16'hB400;
        return bit_out;
    endfunction

    function automatic q_word_t rand_word();
        q_word_t w;
        w = '0;
        for (int i = 0; i < `QUEUE_DWIDTH; i++)
            w = {w[`QUEUE_DWIDTH-2:0], take_bit()};
        return w;
    endfunction

    function automatic apb_data_t ref_status(input int level, input logic ovf);
        apb_data_t w;
        w = '0;
        w[0] = (level == 0);
        w[1] = (level == `QUEUE_DEPTH);
        w[2] = ovf;
        w[8 +: $bits(q_level_t)] = q_level_t'(level);
        return w;
    endfunction

    function automatic logic ref_slverr(input logic write, input apb_addr_t addr, input int level);
        logic mapped;
        mapped = (addr == `QUEUE_ADDR_DATA) || (addr == `QUEUE_ADDR_STATUS);
        return !mapped || (write && addr == `QUEUE_ADDR_DATA && level == `QUEUE_DEPTH);
    endfunction

    function automatic q_item_t ref_item(input q_seq_t tag, input q_word_t word);
        return '{seq: tag, data: word};
    endfunction

    // One transfer, response sampled mid access phase
    task automatic apb_access(input logic write, input apb_addr_t addr, input apb_data_t wdata,
                              output apb_data_t rdata, output logic err);
        @(posedge clk);
        apb_req <= '{psel: 1'b1, penable: 1'b0, pwrite: write, paddr: addr, pwdata: wdata};
        @(posedge clk);
        apb_req.penable <= 1'b1;
        @(negedge clk);
        rdata = apb_rsp.prdata;
        err   = apb_rsp.pslverr;
        check_equal(64'(apb_rsp.pready), 64'(1), "pready");
        check_equal(64'(err), 64'(ref_slverr(write, addr, exp_level)), "pslverr");
        if (!write && addr == `QUEUE_ADDR_STATUS)
            check_equal(64'(rdata), 64'(ref_status(exp_level, exp_ovf)), "STATUS read data");
        @(posedge clk);
        apb_req <= '0;
    endtask

    task automatic apb_write(input apb_addr_t addr, input apb_data_t data, output logic err);
        apb_data_t unused_rd;
        apb_access(1'b1, addr, data, unused_rd, err);
    endtask

    task automatic apb_read(input apb_addr_t addr, output apb_data_t data, output logic err);
        apb_access(1'b0, addr, '0, data, err);
    endtask

    task automatic write_random_word(output logic err);
        @(negedge clk);
        apb_write(`QUEUE_ADDR_DATA, rand_word(), err);
    endtask

    task automatic wait_out_valid();
        do
        begin
            @(negedge clk);
        end
        while (!out_valid);
    endtask

    task automatic wait_drained();
        do
        begin
            @(negedge clk);
        end
        while (stored_q.size() != 0 || exp_q.size() != 0);
    endtask

    // ******************************
    // Reference model and compare
    // ******************************

    always @(posedge clk)
    begin
        logic access;
        logic data_wr;
        logic do_push;
        logic do_pop;
        access  = apb_req.psel & apb_req.penable;
        data_wr = access & apb_req.pwrite & (apb_req.paddr == `QUEUE_ADDR_DATA);
        do_push = data_wr & (exp_level < `QUEUE_DEPTH);
        do_pop  = (~exp_valid | out_ready) & (exp_level > 0);
        if (rst)
        begin
            stored_q.delete();
            exp_q.delete();
            exp_level = 0;
            exp_valid = 1'b0;
            exp_ovf   = 1'b0;
            exp_seq   = '0;
        end
        else
        begin
            if (data_wr & ~do_push)
                exp_ovf = 1'b1;
            else if (access & apb_req.pwrite & (apb_req.paddr == `QUEUE_ADDR_STATUS)
                     & apb_req.pwdata[2])
                exp_ovf = 1'b0;
            // Head moves into the output register
            if (do_pop)
            begin
                exp_q.push_back(ref_item(exp_seq, stored_q.pop_front()));
                exp_seq++;
                exp_level--;
                exp_valid = 1'b1;
            end
            else if (out_ready)
                exp_valid = 1'b0;
            if (do_push)
            begin
                stored_q.push_back(apb_req.pwdata);
                exp_level++;
            end
        end
    end

    always @(posedge clk)
    begin
        q_item_t want;
        if (!rst && out_valid && out_ready)
        begin
            if (exp_q.size() == 0)
            begin
                $display("Stream output gave an item that was never written");
                abort_run();
            end
            else
            begin
                want = exp_q.pop_front();
                check_equal(64'(out_item), 64'(want), "stream item");
                n_seen++;
            end
        end
    end

    // Random back-pressure, one LFSR bit per cycle
    always @(posedge clk)
    begin
        if (random_ready)
            out_ready <= take_bit();
    end

    always @(negedge clk)
    begin
        if (u_cmd_queue_top.u_fifo_flopped.u_fifo_check.fired
            | u_cmd_queue_top.u_apb_cmd_port.u_port_check.fired)
        begin
            $display("A bound assertion on the FIFO or the APB port failed");
            abort_run();
        end
    end

    initial
    begin
        repeat (NUM_OPS * 40) @(posedge clk);
        $display("Timeout after %0d cycles, the run did not finish", NUM_OPS * 40);
        abort_run();
    end

    // ******************************
    // Test sequence
    // ******************************

    initial
    begin
        apb_data_t rd;
        logic      err;
        rst          = 1'b1;
        apb_req      = '0;
        out_ready    = 1'b0;
        random_ready = 1'b0;
        lfsr_state   = 16'd17879;
        n_seen       = 0;
        repeat (8) @(posedge clk);
        rst <= 1'b0;

        @(negedge clk);
        check_equal(64'(out_valid), 64'(0), "out_valid after reset");
        apb_read(`QUEUE_ADDR_STATUS, rd, err);
        check_equal(64'(rd), 64'(ref_status(0, 1'b0)), "STATUS after reset");

        // Sink always ready
        @(posedge clk);
        out_ready <= 1'b1;
        repeat (N_BASIC) write_random_word(err);
        wait_drained();
        check_equal(64'(n_seen), 64'(N_BASIC), "items after in-order run");

        // Fill with the sink stalled, then overflow
        @(posedge clk);
        out_ready <= 1'b0;
        repeat (`QUEUE_DEPTH + 1) write_random_word(err);
        wait_out_valid();
        apb_read(`QUEUE_ADDR_STATUS, rd, err);
        check_equal(64'(rd), 64'(ref_status(`QUEUE_DEPTH, 1'b0)), "STATUS when full");
        write_random_word(err);
        check_equal(64'(err), 64'(1), "pslverr on write to full FIFO");
        apb_read(`QUEUE_ADDR_STATUS, rd, err);
        check_equal(64'(rd), 64'(ref_status(`QUEUE_DEPTH, 1'b1)), "STATUS after overflow");

        // Write 1 to clear, then drain
        apb_write(`QUEUE_ADDR_STATUS, 32'h0000_0004, err);
        apb_read(`QUEUE_ADDR_STATUS, rd, err);
        check_equal(64'(rd), 64'(ref_status(`QUEUE_DEPTH, 1'b0)), "STATUS after clear");
        @(posedge clk);
        out_ready <= 1'b1;
        wait_drained();
        check_equal(64'(n_seen), 64'(N_BASIC + `QUEUE_DEPTH + 1), "items after drain");

        // Unmapped offsets
        apb_write(8'h08, 32'hFFFF_FFFF, err);
        check_equal(64'(err), 64'(1), "pslverr on unmapped write");
        apb_read(8'h0C, rd, err);
        check_equal(64'(err), 64'(1), "pslverr on unmapped read");
        check_equal(64'(rd), 64'(0), "unmapped read data");

        // Random back-pressure, tags wrap past 255
        @(negedge clk);
        random_ready = 1'b1;
        repeat (N_RANDOM) write_random_word(err);
        @(negedge clk);
        random_ready = 1'b0;
        @(posedge clk);
        out_ready <= 1'b1;
        wait_drained();

        if (n_seen != N_BASIC + `QUEUE_DEPTH + 1 + N_RANDOM)
        begin
            $display("Stream output gave %0d items, not the number accepted", n_seen);
            abort_run();
        end
        else
        begin
            $display("All tests passed");
            $finish;
        end
    end

endmodule

/* bench/cmd_queue_checker.sv */
`timescale 1ns/1ps
`include "queue_settings.svh"

module cmd_queue_checker
(
    input logic                clk,
    input logic                rst,
    input logic                push,
    input logic                pop,
    input logic                fifo_full,
    input logic                fifo_empty,
    input queue_pkg::q_level_t fifo_level,
    input apb_pkg::apb_req_t   apb_req,
    input apb_pkg::apb_rsp_t   apb_rsp
);
    import queue_pkg::*;

    logic push_full_hit = 1'b0;
    logic pop_empty_hit = 1'b0;
    logic pready_hit    = 1'b0;
    logic level_hit     = 1'b0;
    logic fired;

    // Set once any assertion below has failed
    assign fired = push_full_hit | pop_empty_hit | pready_hit | level_hit;

    // ******************************
    // FIFO bounds
    // ******************************

    // The FIFO trusts its neighbors to gate push and pop
    a_no_push_full : assert property (@(posedge clk) disable iff (rst) !(push && fifo_full))
        else
        begin
            $error("push while the FIFO is full");
            push_full_hit = 1'b1;
        end

    a_no_pop_empty : assert property (@(posedge clk) disable iff (rst) !(pop && fifo_empty))
        else
        begin
            $error("pop while the FIFO is empty");
            pop_empty_hit = 1'b1;
        end

    a_level_bound : assert property (@(posedge clk) disable iff (rst)
        fifo_level <= q_level_t'(`QUEUE_DEPTH))
        else
        begin
            $error("FIFO level above its depth");
            level_hit = 1'b1;
        end

    // ******************************
    // APB port
    // ******************************

    // No wait states
    a_pready : assert property (@(posedge clk) disable iff (rst)
        (apb_req.psel && apb_req.penable) |-> apb_rsp.pready)
        else
        begin
            $error("pready low in an access phase");
            pready_hit = 1'b1;
        end

endmodule

bind fifo_flopped cmd_queue_checker u_fifo_check
(
    .clk        (clk),
    .rst        (rst),
    .push       (push),
    .pop        (pop),
    .fifo_full  (fifo_full),
    .fifo_empty (fifo_empty),
    .fifo_level (fifo_level),
    .apb_req    ('0),
    .apb_rsp    ('0)
);

bind apb_cmd_port cmd_queue_checker u_port_check
(
    .clk        (clk),
    .rst        (rst),
    .push       (push),
    .pop        (1'b0),
    .fifo_full  (fifo_full),
    .fifo_empty (fifo_empty),
    .fifo_level (fifo_level),
    .apb_req    (apb_req),
    .apb_rsp    (apb_rsp)
);

/* rtl/cmd_queue_top.sv */
`timescale 1ns/1ps
`include "queue_settings.svh"

module cmd_queue_top
(
    input  logic               clk,
    input  logic               rst,
    input  apb_pkg::apb_req_t  apb_req,
    output apb_pkg::apb_rsp_t  apb_rsp,
    output logic               out_valid,
    output queue_pkg::q_item_t out_item,
    input  logic               out_ready
);
    import queue_pkg::*;

    logic     push;
    q_word_t  push_data;
    logic     pop;
    q_word_t  head_data;
    logic     fifo_full;
    logic     fifo_empty;
    q_level_t fifo_level;

    // APB producer side
    apb_cmd_port u_apb_cmd_port
    (
        .clk        (clk),
        .rst        (rst),
        .apb_req    (apb_req),
        .apb_rsp    (apb_rsp),
        .fifo_full  (fifo_full),
        .fifo_empty (fifo_empty),
        .fifo_level (fifo_level),
        .push       (push),
        .push_data  (push_data)
    );

    fifo_flopped
    #(
        .DWIDTH (`QUEUE_DWIDTH),
        .DEPTH  (`QUEUE_DEPTH)
    )
    u_fifo_flopped
    (
        .clk        (clk),
        .rst        (rst),
        .push       (push),
        .push_data  (push_data),
        .pop        (pop),
        .head_data  (head_data),
        .fifo_full  (fifo_full),
        .fifo_empty (fifo_empty),
        .fifo_level (fifo_level)
    );

    // Stream consumer side
    cmd_drain u_cmd_drain
    (
        .clk        (clk),
        .rst        (rst),
        .head_data  (head_data),
        .fifo_empty (fifo_empty),
        .pop        (pop),
        .out_valid  (out_valid),
        .out_item   (out_item),
        .out_ready  (out_ready)
    );

endmodule

/* rtl/cmd_drain.sv */
`timescale 1ns/1ps

module cmd_drain
(
    input  logic               clk,
    input  logic               rst,
    input  queue_pkg::q_word_t head_data,
    input  logic               fifo_empty,
    output logic               pop,
    output logic               out_valid,
    output queue_pkg::q_item_t out_item,
    input  logic               out_ready
);
    import queue_pkg::*;

    q_seq_t seq;
    logic   slot_free;

    // ******************************
    // Pop decision
    // ******************************

    // Output register empty now or leaving this cycle
    assign slot_free = ~out_valid | out_ready;

    // Refill in the same cycle as an accept
    assign pop = slot_free & ~fifo_empty;

    // ******************************
    // Output register
    // ******************************

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            out_valid <= 1'b0;
        end
        else if (pop)
        begin
            out_valid <= 1'b1;
        end
        else if (out_ready)
        begin
            out_valid <= 1'b0;
        end
    end

    // Payload, held while the sink stalls
    always_ff @(posedge clk)
    begin
        if (pop)
        begin
            out_item.seq  <= seq;
            out_item.data <= head_data;
        end
    end

    // Tag for the next loaded word, wraps 255 to 0
    always_ff @(posedge clk)
    begin
        if (rst)
            seq <= '0;
        else if (pop)
            seq <= seq + q_seq_t'(1);
    end

endmodule

/* rtl/fifo_flopped.sv */
`timescale 1ns/1ps

module fifo_flopped
#(
    parameter int DWIDTH = 32,
    parameter int DEPTH  = 16
)
(
    input  logic                clk,
    input  logic                rst,
    input  logic                push,
    input  queue_pkg::q_word_t  push_data,
    input  logic                pop,
    output queue_pkg::q_word_t  head_data,
    output logic                fifo_full,
    output logic                fifo_empty,
    output queue_pkg::q_level_t fifo_level
);
    import queue_pkg::*;

    // Pointer width, at least one bit
    localparam int AWIDTH = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    typedef logic [AWIDTH-1:0] ptr_t;

    ptr_t              wr_ptr;
    ptr_t              rd_ptr;
    logic [DEPTH-1:0]  wr_en;
    logic [DWIDTH-1:0] mem [DEPTH];
    q_level_t          count;

    // Advance with wrap at DEPTH, also for depths off a power of two
    function automatic ptr_t next_ptr(input ptr_t ptr);
        ptr_t nxt;
        if (ptr == ptr_t'(DEPTH - 1))
            nxt = '0;
        else
            nxt = ptr + ptr_t'(1);
        return nxt;
    endfunction

    // ******************************
    // Pointers
    // ******************************

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end
        else
        begin
            if (push)
                wr_ptr <= next_ptr(wr_ptr);
            if (pop)
                rd_ptr <= next_ptr(rd_ptr);
        end
    end

    // ******************************
    // Storage
    // ******************************

    // One-hot entry select
    always_comb
    begin
        wr_en = '0;
        if (push)
            wr_en[wr_ptr] = 1'b1;
    end

    for (genvar i = 0; i < DEPTH; i++)
    begin : g_entry
        always_ff @(posedge clk)
        begin
            if (wr_en[i])
                mem[i] <= push_data;
        end
    end

    assign head_data = mem[rd_ptr];

    // Entry counter, full and empty come from here
    always_ff @(posedge clk)
    begin
        if (rst)
            count <= '0;
        else if (push & ~pop)
            count <= count + q_level_t'(1);
        else if (pop & ~push)
            count <= count - q_level_t'(1);
    end

    assign fifo_level = count;
    assign fifo_full  = (count == q_level_t'(DEPTH));
    assign fifo_empty = (count == '0);

endmodule

/* rtl/apb_cmd_port.sv */
`timescale 1ns/1ps
`include "queue_settings.svh"

module apb_cmd_port
(
    input  logic                clk,
    input  logic                rst,
    input  apb_pkg::apb_req_t   apb_req,
    output apb_pkg::apb_rsp_t   apb_rsp,
    input  logic                fifo_full,
    input  logic                fifo_empty,
    input  queue_pkg::q_level_t fifo_level,
    output logic                push,
    output queue_pkg::q_word_t  push_data
);
    import apb_pkg::*;
    import queue_pkg::*;

    // STATUS bit positions
    localparam int STAT_EMPTY = 0;
    localparam int STAT_FULL  = 1;
    localparam int STAT_OVF   = 2;
    localparam int STAT_LEVEL = 8;

    logic      access;
    logic      hit_data;
    logic      hit_status;
    logic      data_write;
    logic      full_write;
    logic      status_read;
    logic      ovf_clear;
    logic      overflow;
    apb_data_t status_word;

    // ******************************
    // Address decode
    // ******************************

    // Access phase, always completes without wait states
    assign access     = apb_req.psel & apb_req.penable;
    assign hit_data   = (apb_req.paddr == `QUEUE_ADDR_DATA);
    assign hit_status = (apb_req.paddr == `QUEUE_ADDR_STATUS);

    assign data_write  = access & apb_req.pwrite & hit_data;
    assign status_read = access & ~apb_req.pwrite & hit_status;

    // Word is dropped when the FIFO has no room
    assign push       = data_write & ~fifo_full;
    assign push_data  = apb_req.pwdata;
    assign full_write = data_write & fifo_full;

    // Write 1 to clear
    assign ovf_clear = access & apb_req.pwrite & hit_status & apb_req.pwdata[STAT_OVF];

    // ******************************
    // Sticky overflow flag
    // ******************************

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            overflow <= 1'b0;
        end
        else if (full_write)
        begin
            overflow <= 1'b1;
        end
        else if (ovf_clear)
        begin
            overflow <= 1'b0;
        end
    end

    // ******************************
    // Read data and response
    // ******************************

    always_comb
    begin
        status_word                                  = '0;
        status_word[STAT_EMPTY]                      = fifo_empty;
        status_word[STAT_FULL]                       = fifo_full;
        status_word[STAT_OVF]                        = overflow;
        status_word[STAT_LEVEL +: $bits(q_level_t)]  = fifo_level;
    end

    assign apb_rsp.pready  = access;

    // Error on a full DATA write or on any unmapped offset
    assign apb_rsp.pslverr = full_write | (access & ~(hit_data | hit_status));

    // DATA and unmapped offsets read as zero
    assign apb_rsp.prdata  = status_read ? status_word : '0;

endmodule

/* rtl/queue_pkg.sv */
`include "queue_settings.svh"

package queue_pkg;

    // One command word as stored in the FIFO
    typedef logic [`QUEUE_DWIDTH-1:0] q_word_t;

    // Entry count, must reach QUEUE_DEPTH itself
    typedef logic [$clog2(`QUEUE_DEPTH + 1)-1:0] q_level_t;

    // Sequence tag, wraps at 256
    typedef logic [7:0] q_seq_t;

    // Item on the stream output
    typedef struct packed {
        q_seq_t  seq;
        q_word_t data;
    } q_item_t;

endpackage

/* rtl/apb_pkg.sv */
package apb_pkg;

    // Register offset within the slave
    typedef logic [7:0] apb_addr_t;

    // Bus data word
    typedef logic [31:0] apb_data_t;

    // Master to slave
    typedef struct packed {
        logic      psel;
        logic      penable;
        logic      pwrite;
        apb_addr_t paddr;
        apb_data_t pwdata;
    } apb_req_t;

    // Slave to master
    typedef struct packed {
        logic      pready;
        logic      pslverr;
        apb_data_t prdata;
    } apb_rsp_t;

endpackage

/* rtl/queue_settings.svh */
`ifndef QUEUE_SETTINGS_SVH
`define QUEUE_SETTINGS_SVH

// ******************************
// Queue data path
// ******************************

// Width of one command word
`define QUEUE_DWIDTH 32

// FIFO entries, any value of 1 or more
`define QUEUE_DEPTH 16

// ******************************
// APB register map
// ******************************

`define QUEUE_ADDR_DATA 8'h00
`define QUEUE_ADDR_STATUS 8'h04

`endif
